// File: design/i2c_byte_engine.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module i2c_byte_engine (
	input  logic                i_CLK,
	input  logic                i_RSTN,
	input  mpr121_pkg::i2c_op_t i_op,
	input  logic                i_op_valid,
	input  logic                i_scl,
	input  logic                i_sda,
	output logic                o_op_ready,
	output logic                o_op_done,
	output logic [7:0]          o_rx_byte,
	output logic                o_got_nack,
	output logic                o_scl_oe,
	output logic                o_sda_oe
);
	import mpr121_pkg::*;

	localparam int QDIV = `MPR121_I2C_QDIV;
	localparam int DW   = (QDIV > 1) ? $clog2(QDIV) : 1;

	logic          busy;
	i2c_op_kind_e  kind;
	logic [DW-1:0] div;       // cycles within a quarter
	logic [1:0]    qtr;       // quarter within a bit
	logic [3:0]    bcnt;      // bit 8 is the ack slot
	logic [7:0]    shreg;     // tx byte, fills with ones
	logic          tick;
	logic          last;
	logic          finish;
	logic [1:0]    q_next;
	logic [3:0]    b_next;
	logic [7:0]    sh_next;
	logic [1:0]    oe_next;   // {scl, sda}
	logic [1:0]    oe_first;

	// line enables per quarter, 1 pulls low
	function automatic logic [1:0] line_oe(i2c_op_kind_e k, logic [1:0] q, logic bit_val);
		logic [1:0] oe;
		case (k)
			OP_START:   oe = {q == 2'd3, q[1]};                // sda falls in q2, scl high
			OP_RESTART: oe = {q == 2'd0 || q == 2'd3, q[1]};   // release sda first, scl low
			OP_STOP:    oe = {q == 2'd0, ~q[1]};               // sda rises in q2, scl high
			default:    oe = {q == 2'd0 || q == 2'd3, ~bit_val}; // data bit, high in q1/q2
		endcase
		return oe;
	endfunction

	assign tick    = busy && (div == DW'(QDIV - 1));
	assign last    = (kind == OP_WRITE || kind == OP_READ_NACK) ? (bcnt == 4'd8) : 1'b1;
	assign finish  = tick && (qtr == 2'd3) && last;
	assign q_next  = qtr + 2'd1;
	assign b_next  = (qtr == 2'd3) ? bcnt + 4'd1 : bcnt;
	assign sh_next = (qtr == 2'd3) ? {shreg[6:0], 1'b1} : shreg;   // ack slot sees a 1
	assign oe_next = line_oe(kind, q_next, (kind == OP_WRITE) ? sh_next[7] : 1'b1);
	// reads keep sda released, also gives the final nack
	assign oe_first = line_oe(i_op.kind, 2'd0, (i_op.kind == OP_WRITE) ? i_op.data[7] : 1'b1);
	assign o_op_ready = !busy;

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			busy       <= 1'b0;
			div        <= '0;
			qtr        <= 2'd0;
			bcnt       <= 4'd0;
			o_op_done  <= 1'b0;
			o_got_nack <= 1'b0;
			o_scl_oe   <= 1'b0;   // both lines released
			o_sda_oe   <= 1'b0;
		end
		else
		begin
			o_op_done <= finish;
			if (!busy)
			begin
				if (i_op_valid)
				begin
					busy       <= 1'b1;
					div        <= '0;
					qtr        <= 2'd0;
					bcnt       <= 4'd0;
					o_got_nack <= 1'b0;
					{o_scl_oe, o_sda_oe} <= oe_first;
				end
			end
			else if (tick)
			begin
				div <= '0;
				if (finish)
					busy <= 1'b0;   // lines hold until the next op
				else
				begin
					qtr  <= q_next;
					bcnt <= b_next;
					{o_scl_oe, o_sda_oe} <= oe_next;
				end
				// ack slot at scl high midpoint, only counts with scl really high
				if (qtr == 2'd1 && kind == OP_WRITE && bcnt == 4'd8)
					o_got_nack <= i_sda || !i_scl;
			end
			else
				div <= div + 1'b1;
		end
	end

	always_ff @(posedge i_CLK)
	begin
		if (!busy && i_op_valid)
		begin
			kind  <= i_op.kind;
			shreg <= i_op.data;
		end
		else if (tick)
		begin
			shreg <= sh_next;
			if (qtr == 2'd1 && kind == OP_READ_NACK && bcnt < 4'd8)
				o_rx_byte <= {o_rx_byte[6:0], i_sda};   // msb first
		end
	end

endmodule

// File: design/mpr121_cmd_fifo.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module mpr121_cmd_fifo #(
	parameter int AW = `MPR121_FIFO_AW
) (
	input  logic                    i_CLK,
	input  logic                    i_RSTN,
	input  logic                    i_push,
	input  mpr121_pkg::mpr121_cmd_t i_push_cmd,
	input  logic                    i_pop,
	output mpr121_pkg::mpr121_cmd_t o_head,
	output logic                    o_empty,
	output logic                    o_full
);
	import mpr121_pkg::*;

	mpr121_cmd_t mem [2**AW];
	logic [AW:0] wr_ptr;   // msb is the wrap bit
	logic [AW:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign o_head  = mem[rd_ptr[AW-1:0]];   // valid whenever not empty

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_CLK)
	begin
		if (i_push && !o_full)
			mem[wr_ptr[AW-1:0]] <= i_push_cmd;
	end

endmodule

// File: design/mpr121_pkg.sv
package mpr121_pkg;

	// ====================
	// host side
	// ====================
	typedef struct packed {
		logic       is_read;   // 1 = register read
		logic [7:0] reg_addr;
		logic [7:0] wdata;     // ignored on reads
	} mpr121_cmd_t;

	typedef struct packed {
		logic       fifo_full;  // bit 11
		logic       fail;       // last transfer missed an ack
		logic       busy;
		logic       init_done;
		logic [7:0] rdata;      // bits 7..0
	} mpr121_status_t;

	// sequencer -> front end, init_done goes on its own wire
	typedef struct packed {
		logic       busy;
		logic       fail;
		logic [7:0] rdata;
	} mpr121_seq_result_t;

	// ====================
	// byte engine ops
	// ====================
	typedef enum logic [2:0] {
		OP_START,
		OP_RESTART,
		OP_WRITE,     // byte out, slave acks
		OP_READ_NACK, // byte in, master nacks
		OP_STOP
	} i2c_op_kind_e;

	typedef struct packed {
		i2c_op_kind_e kind;
		logic [7:0]   data;
	} i2c_op_t;

endpackage

// File: design/mpr121_sequencer.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module mpr121_sequencer (
	input  logic                           i_CLK,
	input  logic                           i_RSTN,
	input  mpr121_pkg::mpr121_cmd_t        i_head,
	input  logic                           i_empty,
	input  logic                           i_scl,
	input  logic                           i_sda,
	output logic                           o_pop,
	output mpr121_pkg::mpr121_seq_result_t o_result,
	output logic                           o_init_done,
	output logic                           o_scl_oe,
	output logic                           o_sda_oe
);
	import mpr121_pkg::*;

	localparam int SETTLE = `MPR121_SETTLE_CYCLES;
	localparam int SW     = $clog2(SETTLE);
	localparam logic [7:0] ADDR_W = {`MPR121_DEV_ADDR, 1'b0};
	localparam logic [7:0] ADDR_R = {`MPR121_DEV_ADDR, 1'b1};

	typedef enum logic [2:0] {S_BOOT, S_IDLE, S_ISSUE, S_WAIT, S_SETTLE} seq_state_e;

	seq_state_e    state;
	mpr121_cmd_t   cur;         // command in flight
	logic [2:0]    step;        // index into the op list
	logic [2:0]    stop_step;
	logic [SW-1:0] settle_cnt;
	logic          fail_r;
	logic [7:0]    rdata_r;
	i2c_op_t       op;
	logic          op_valid;
	logic          op_ready;
	logic          op_done;
	logic          got_nack;
	logic [7:0]    rx_byte;

	// ====================
	// op list per command
	// ====================
	always_comb
	begin
		case ({cur.is_read, step})
			4'b0_000, 4'b1_000: op = '{kind: OP_START, data: 8'h00};
			4'b0_001, 4'b1_001: op = '{kind: OP_WRITE, data: ADDR_W};
			4'b0_010, 4'b1_010: op = '{kind: OP_WRITE, data: cur.reg_addr};
			4'b0_011:           op = '{kind: OP_WRITE, data: cur.wdata};
			4'b1_011:           op = '{kind: OP_RESTART, data: 8'h00};
			4'b1_100:           op = '{kind: OP_WRITE, data: ADDR_R};
			4'b1_101:           op = '{kind: OP_READ_NACK, data: 8'h00};
			default:            op = '{kind: OP_STOP, data: 8'h00};
		endcase
	end

	assign stop_step = cur.is_read ? 3'd6 : 3'd4;   // skip ahead here on a nack
	assign op_valid  = (state == S_ISSUE);
	assign o_pop     = (state == S_IDLE) && !i_empty;
	// queued commands count as busy too
	assign o_result  = '{busy: (state != S_IDLE) || !i_empty, fail: fail_r, rdata: rdata_r};

	// command register, soft reset pair on boot
	always_ff @(posedge i_CLK)
	begin
		if (state == S_BOOT)
			cur <= '{is_read: 1'b0, reg_addr: `MPR121_SOFT_RESET_REG,
				wdata: `MPR121_SOFT_RESET_VAL};
		else if (o_pop)
			cur <= i_head;
	end

	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
		begin
			state       <= S_BOOT;
			step        <= 3'd0;
			settle_cnt  <= '0;
			fail_r      <= 1'b0;
			rdata_r     <= 8'h00;
			o_init_done <= 1'b0;
		end
		else
		begin
			case (state)
				S_BOOT:
					state <= S_ISSUE;
				S_IDLE:
				begin
					if (!i_empty)
					begin
						step   <= 3'd0;
						fail_r <= 1'b0;   // fail is per transfer
						state  <= S_ISSUE;
					end
				end
				S_ISSUE:
				begin
					if (op_ready)
						state <= S_WAIT;
				end
				S_WAIT:
				begin
					if (op_done)
					begin
						if (op.kind == OP_READ_NACK)
							rdata_r <= rx_byte;
						if (op.kind == OP_STOP)
						begin
							settle_cnt <= '0;
							state      <= cur.is_read ? S_IDLE : S_SETTLE;
						end
						else if (got_nack)
						begin
							fail_r <= 1'b1;
							step   <= stop_step;   // still close the bus
							state  <= S_ISSUE;
						end
						else
						begin
							step  <= step + 3'd1;
							state <= S_ISSUE;
						end
					end
				end
				S_SETTLE:
				begin
					if (settle_cnt == SW'(SETTLE - 1))
					begin
						o_init_done <= 1'b1;   // first write is always the soft reset
						state       <= S_IDLE;
					end
					else
						settle_cnt <= settle_cnt + 1'b1;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	i2c_byte_engine u_engine (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_op       (op),
		.i_op_valid (op_valid),
		.i_scl      (i_scl),
		.i_sda      (i_sda),
		.o_op_ready (op_ready),
		.o_op_done  (op_done),
		.o_rx_byte  (rx_byte),
		.o_got_nack (got_nack),
		.o_scl_oe   (o_scl_oe),
		.o_sda_oe   (o_sda_oe)
	);

endmodule

// File: design/mpr121_settings.svh
`ifndef MPR121_SETTINGS_SVH
`define MPR121_SETTINGS_SVH

// ====================
// sensor on the bus
// ====================
`define MPR121_DEV_ADDR        7'h5A    // ADDR pin tied low
`define MPR121_SOFT_RESET_REG  8'h80
`define MPR121_SOFT_RESET_VAL  8'h63

// timing, in i_CLK cycles
`define MPR121_I2C_QDIV        4        // quarter of one scl period
`define MPR121_SETTLE_CYCLES   16       // idle gap after a write

`define MPR121_FIFO_AW         2        // 4 commands deep

// wishbone register map
`define MPR121_WB_ADR_CMD      1'b0
`define MPR121_WB_ADR_STATUS   1'b1

`endif

// File: design/mpr121_top.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module mpr121_top (
	input  logic        i_CLK,
	input  logic        i_RSTN,
	input  logic        i_wb_cyc,
	input  logic        i_wb_stb,
	input  logic        i_wb_we,
	input  logic        i_wb_adr,
	input  logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack,
	input  logic        i_scl,
	input  logic        i_sda,
	output logic        o_scl_oe,   // open drain, pad merge on the board
	output logic        o_sda_oe
);
	import mpr121_pkg::*;

	logic               push;
	mpr121_cmd_t        push_cmd;
	mpr121_cmd_t        head;
	logic               fifo_empty;
	logic               fifo_full;
	logic               pop;
	mpr121_seq_result_t result;
	logic               init_done;

	// ====================
	// producer
	// ====================
	mpr121_wb_regs u_regs (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_wb_cyc    (i_wb_cyc),
		.i_wb_stb    (i_wb_stb),
		.i_wb_we     (i_wb_we),
		.i_wb_adr    (i_wb_adr),
		.i_wb_dat    (i_wb_dat),
		.i_fifo_full (fifo_full),
		.i_result    (result),
		.i_init_done (init_done),
		.o_wb_dat    (o_wb_dat),
		.o_wb_ack    (o_wb_ack),
		.o_push      (push),
		.o_push_cmd  (push_cmd)
	);

	mpr121_cmd_fifo #(.AW(`MPR121_FIFO_AW)) u_fifo (
		.i_CLK      (i_CLK),
		.i_RSTN     (i_RSTN),
		.i_push     (push),
		.i_push_cmd (push_cmd),
		.i_pop      (pop),
		.o_head     (head),
		.o_empty    (fifo_empty),
		.o_full     (fifo_full)
	);

	// consumer, owns the byte engine
	mpr121_sequencer u_seq (
		.i_CLK       (i_CLK),
		.i_RSTN      (i_RSTN),
		.i_head      (head),
		.i_empty     (fifo_empty),
		.i_scl       (i_scl),
		.i_sda       (i_sda),
		.o_pop       (pop),
		.o_result    (result),
		.o_init_done (init_done),
		.o_scl_oe    (o_scl_oe),
		.o_sda_oe    (o_sda_oe)
	);

endmodule

// File: design/mpr121_wb_regs.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module mpr121_wb_regs (
	input  logic                           i_CLK,
	input  logic                           i_RSTN,
	input  logic                           i_wb_cyc,
	input  logic                           i_wb_stb,
	input  logic                           i_wb_we,
	input  logic                           i_wb_adr,
	input  logic [31:0]                    i_wb_dat,
	input  logic                           i_fifo_full,
	input  mpr121_pkg::mpr121_seq_result_t i_result,
	input  logic                           i_init_done,
	output logic [31:0]                    o_wb_dat,
	output logic                           o_wb_ack,
	output logic                           o_push,
	output mpr121_pkg::mpr121_cmd_t        o_push_cmd
);
	import mpr121_pkg::*;

	logic           req;     // new cycle, not yet acked
	logic           cmd_wr;
	logic           accept;
	mpr121_status_t status;

	assign req    = i_wb_cyc && i_wb_stb && !o_wb_ack;     // no double accept in ack cycle
	assign cmd_wr = req && i_wb_we && (i_wb_adr == `MPR121_WB_ADR_CMD);
	assign accept = req && !(cmd_wr && i_fifo_full);        // stall cmd writes on full
	assign o_push = cmd_wr && !i_fifo_full;
	assign o_push_cmd = i_wb_dat[16:0];                     // low 17 bits = command

	assign status = '{fifo_full: i_fifo_full, fail: i_result.fail, busy: i_result.busy,
		init_done: i_init_done, rdata: i_result.rdata};

	// one-cycle ack, one cycle after accept
	always_ff @(posedge i_CLK or negedge i_RSTN)
	begin
		if (!i_RSTN)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= accept;
	end

	// read data, zero for cmd reads and for writes
	always_ff @(posedge i_CLK)
	begin
		if (accept && !i_wb_we && i_wb_adr == `MPR121_WB_ADR_STATUS)
			o_wb_dat <= {20'd0, status};
		else
			o_wb_dat <= 32'd0;
	end

endmodule

// File: verification/mpr121_asserts.sv
`timescale 1ns/100ps

module mpr121_asserts (
	input logic i_CLK,
	input logic i_RSTN,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_scl,
	input logic i_sda,
	input logic i_sda_oe
);
	int fail_count = 0;   // failed assertions so far

	// ack only for a live request
	a_ack_with_req: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_wb_ack |-> (i_wb_cyc && i_wb_stb))
	else
	begin
		fail_count++;
		$error("wishbone ack without cyc and stb");
	end

	a_ack_one_cycle: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		i_wb_ack |=> !i_wb_ack)
	else
	begin
		fail_count++;
		$error("wishbone ack high two cycles running");
	end

	// sda moving under high scl must be a master start or stop, scl stays up
	a_sda_start_stop: assert property (@(posedge i_CLK) disable iff (!i_RSTN)
		(i_sda != $past(i_sda)) && i_scl && $past(i_scl)
		|-> (i_sda_oe != $past(i_sda_oe)) ##1 i_scl)
	else
	begin
		fail_count++;
		$error("sda changed while scl high outside a start or stop");
	end

endmodule

bind mpr121_top mpr121_asserts u_asserts (
	.i_CLK    (i_CLK),
	.i_RSTN   (i_RSTN),
	.i_wb_cyc (i_wb_cyc),
	.i_wb_stb (i_wb_stb),
	.i_wb_ack (o_wb_ack),
	.i_scl    (i_scl),
	.i_sda    (i_sda),
	.i_sda_oe (o_sda_oe)
);

// File: verification/mpr121_i2c_model.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module mpr121_i2c_model (
	input  logic i_scl,
	input  logic i_sda,
	input  logic i_force_nack,   // refuse the device address
	output logic o_sda_oe        // 1 pulls sda low
);
	typedef enum logic [2:0] {PH_IDLE, PH_ADDR, PH_REG, PH_WDATA, PH_READ} phase_e;

	logic [7:0] regs [256];
	phase_e     phase;
	logic [3:0] bit_cnt;       // scl rises seen in this byte, 9 = ack slot clocked
	logic [7:0] shift;
	logic [7:0] ptr;           // register pointer, auto increment
	logic       addr_ok;
	logic       rd_mode;
	logic       master_nack;
	int         i;

	initial
	begin
		for (i = 0; i < 256; i++)
			regs[i] = 8'(i) ^ 8'h96;   // fill pattern over the whole address
		phase       = PH_IDLE;
		bit_cnt     = 4'd0;
		shift       = 8'h00;
		ptr         = 8'h00;
		addr_ok     = 1'b0;
		rd_mode     = 1'b0;
		master_nack = 1'b1;
		o_sda_oe    = 1'b0;
	end

	// ====================
	// start and stop
	// ====================
	always @(negedge i_sda)
	begin
		if (i_scl === 1'b1)
		begin
			phase    = PH_ADDR;   // start or repeated start
			bit_cnt  = 4'd0;
			o_sda_oe = 1'b0;
		end
	end

	always @(posedge i_sda)
	begin
		if (i_scl === 1'b1)
			phase = PH_IDLE;   // stop
	end

	// sample on rising scl
	always @(posedge i_scl)
	begin
		if (phase != PH_IDLE)
		begin
			if (bit_cnt < 4'd8)
			begin
				if (phase != PH_READ)
					shift = {shift[6:0], i_sda};   // msb first
			end
			else
				master_nack = i_sda;   // ack slot, only used when sending
			bit_cnt = bit_cnt + 4'd1;
		end
	end

	// ====================
	// drive on falling scl
	// ====================
	always @(negedge i_scl)
	begin
		if (phase != PH_IDLE)
		begin
			if (bit_cnt == 4'd8)
			begin
				case (phase)
					PH_ADDR:
					begin
						addr_ok  = (shift[7:1] == `MPR121_DEV_ADDR) && !i_force_nack;
						rd_mode  = shift[0];
						o_sda_oe = addr_ok;
					end
					PH_REG:
					begin
						ptr      = shift;
						o_sda_oe = 1'b1;
					end
					PH_WDATA:
					begin
						regs[ptr] = shift;
						ptr       = ptr + 8'd1;
						o_sda_oe  = 1'b1;
					end
					default:
						o_sda_oe = 1'b0;   // master answers a read byte
				endcase
			end
			else if (bit_cnt == 4'd9)
			begin
				bit_cnt  = 4'd0;   // ack slot over
				o_sda_oe = 1'b0;
				case (phase)
					PH_ADDR:
						phase = !addr_ok ? PH_IDLE : (rd_mode ? PH_READ : PH_REG);
					PH_REG:
						phase = PH_WDATA;
					PH_READ:
					begin
						if (master_nack)
							phase = PH_IDLE;
						else
							ptr = ptr + 8'd1;
					end
					default:
						phase = phase;
				endcase
				if (phase == PH_READ)
				begin
					shift    = regs[ptr];
					o_sda_oe = !shift[7];
				end
			end
			else if (phase == PH_READ && bit_cnt != 4'd0)
			begin
				shift    = {shift[6:0], 1'b1};   // next bit to the top
				o_sda_oe = !shift[7];
			end
		end
	end

endmodule

// File: verification/tb_mpr121.sv
`timescale 1ns/100ps
`include "mpr121_settings.svh"

module tb_mpr121;
	import mpr121_pkg::*;

	localparam int MAX_CYCLES = 20000;   // ~20 transfers of ~700 cycles, plus margin

	logic        clk;
	logic        rst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic        wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic        dut_scl_oe;
	logic        dut_sda_oe;
	logic        model_sda_oe;
	logic        force_nack;
	wire         scl_line;
	wire         sda_line;
	int          errors;
	int          cycles;
	int          seed;
	logic [7:0]  exp_rdata;     // last value read back
	logic        rdata_known;

	// open drain, pulled up
	assign scl_line = !dut_scl_oe;
	assign sda_line = !(dut_sda_oe || model_sda_oe);

	mpr121_top i_dut (
		.i_CLK    (clk),
		.i_RSTN   (rst_n),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack),
		.i_scl    (scl_line),
		.i_sda    (sda_line),
		.o_scl_oe (dut_scl_oe),
		.o_sda_oe (dut_sda_oe)
	);

	mpr121_i2c_model u_model (
		.i_scl        (scl_line),
		.i_sda        (sda_line),
		.i_force_nack (force_nack),
		.o_sda_oe     (model_sda_oe)
	);

	always #50 clk = ~clk;

	// ====================
	// bus tasks
	// ====================
	task automatic wb_access(input logic we, input logic adr, input logic [31:0] dat_w,
		output logic [31:0] dat_r);
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat_w;
		do
			@(negedge clk);
		while (!wb_ack);
		dat_r = wb_dat_r;
		@(negedge clk);   // ack taken at the rising edge, release after it
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic adr, input logic [31:0] dat);
		logic [31:0] unused;
		wb_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic adr, output logic [31:0] dat);
		wb_access(1'b0, adr, 32'd0, dat);
	endtask

	task automatic send_cmd(input logic rd, input logic [7:0] addr, input logic [7:0] data);
		mpr121_cmd_t cmd;
		cmd = '{is_read: rd, reg_addr: addr, wdata: data};
		wb_write(`MPR121_WB_ADR_CMD, {15'd0, cmd});
	endtask

	task automatic read_status(output mpr121_status_t st);
		logic [31:0] word;
		wb_read(`MPR121_WB_ADR_STATUS, word);
		st = word[11:0];
	endtask

	task automatic wait_idle(output mpr121_status_t st);
		do
			read_status(st);
		while (st.busy);
	endtask

	// ====================
	// compare tasks
	// ====================
	task automatic report_mismatch(input string what, input string name, input logic [7:0] got,
		input logic [7:0] want);
		errors++;
		$display("FAIL %s: %s = 0x%h, expected 0x%h", what, name, got, want);
	endtask

	task automatic check_status(input string what, input mpr121_status_t got,
		input mpr121_status_t want);
		if (got.fifo_full !== want.fifo_full)
			report_mismatch(what, "status.fifo_full", 8'(got.fifo_full), 8'(want.fifo_full));
		if (got.fail !== want.fail)
			report_mismatch(what, "status.fail", 8'(got.fail), 8'(want.fail));
		if (got.busy !== want.busy)
			report_mismatch(what, "status.busy", 8'(got.busy), 8'(want.busy));
		if (got.init_done !== want.init_done)
			report_mismatch(what, "status.init_done", 8'(got.init_done), 8'(want.init_done));
		if (rdata_known && got.rdata !== want.rdata)
			report_mismatch(what, "status.rdata", got.rdata, want.rdata);
	endtask

	task automatic check_byte(input string what, input logic [7:0] addr, input logic [7:0] want);
		if (u_model.regs[addr] !== want)
			report_mismatch(what, $sformatf("model reg[0x%h]", addr), u_model.regs[addr], want);
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want)
			report_mismatch("after reset", name, 8'(got), 8'(want));
	endtask

	function automatic mpr121_status_t idle_status(input logic want_fail);
		mpr121_status_t st;
		st = '{fifo_full: 1'b0, fail: want_fail, busy: 1'b0, init_done: 1'b1, rdata: exp_rdata};
		return st;
	endfunction

	function automatic logic [7:0] pick_reg();
		logic [7:0] r;
		do
			r = 8'($random(seed));
		while (r == `MPR121_SOFT_RESET_REG);
		return r;
	endfunction

	// ====================
	// directed tests
	// ====================
	task automatic test_idle_after_reset();
		check_bit("o_wb_ack", wb_ack, 1'b0);
		check_bit("o_scl_oe", dut_scl_oe, 1'b0);
		check_bit("o_sda_oe", dut_sda_oe, 1'b0);
	endtask

	task automatic test_init();
		mpr121_status_t st;
		wait_idle(st);
		check_status("init", st, idle_status(1'b0));
		check_byte("init", `MPR121_SOFT_RESET_REG, `MPR121_SOFT_RESET_VAL);
	endtask

	task automatic test_write_read();
		mpr121_status_t st;
		logic [7:0]     addr;
		logic [7:0]     val;
		addr = pick_reg();
		val  = 8'($random(seed));
		if (val == u_model.regs[addr])
			val = ~val;   // make the write visible
		send_cmd(1'b0, addr, val);
		wait_idle(st);
		check_status("write", st, idle_status(1'b0));
		check_byte("write", addr, val);
		send_cmd(1'b1, addr, 8'h00);
		wait_idle(st);
		exp_rdata   = val;
		rdata_known = 1'b1;
		check_status("read back", st, idle_status(1'b0));
	endtask

	task automatic test_backpressure();
		mpr121_status_t st;
		mpr121_status_t want;
		logic [7:0]     addrs [6];
		logic [7:0]     vals [6];
		logic [31:0]    r;
		int             k;
		for (k = 0; k < 6; k++)
		begin
			r        = $random(seed);
			addrs[k] = {2'b00, 3'(k + 2), r[2:0]};   // distinct, 0x10..0x3f
			vals[k]  = r[15:8];
			if (vals[k] == u_model.regs[addrs[k]])
				vals[k] = ~vals[k];
		end
		for (k = 0; k < 5; k++)
			send_cmd(1'b0, addrs[k], vals[k]);
		read_status(st);   // one in flight, four queued
		want           = idle_status(1'b0);
		want.fifo_full = 1'b1;
		want.busy      = 1'b1;
		check_status("queue full", st, want);
		send_cmd(1'b0, addrs[5], vals[5]);   // held off until a slot frees
		wait_idle(st);
		check_status("queued writes", st, idle_status(1'b0));
		for (k = 0; k < 6; k++)
			check_byte("queued writes", addrs[k], vals[k]);
		for (k = 0; k < 6; k++)
		begin
			send_cmd(1'b1, addrs[k], 8'h00);
			wait_idle(st);
			exp_rdata = vals[k];
			check_status("queued read back", st, idle_status(1'b0));
		end
	endtask

	task automatic test_nack();
		mpr121_status_t st;
		logic [7:0]     addr;
		logic [7:0]     val;
		logic [7:0]     old;
		addr = pick_reg();
		val  = 8'($random(seed));
		old  = u_model.regs[addr];
		if (val == old)
			val = ~val;
		@(negedge clk);
		force_nack = 1'b1;
		send_cmd(1'b0, addr, val);
		wait_idle(st);
		check_status("nacked write", st, idle_status(1'b1));
		check_byte("nacked write", addr, old);
		@(negedge clk);
		force_nack = 1'b0;
		send_cmd(1'b0, addr, val);
		wait_idle(st);
		check_status("write after nack", st, idle_status(1'b0));
		check_byte("write after nack", addr, val);
	endtask

	task automatic report_counts();
		$display("error count: %0d checks, %0d assertions", errors,
			i_dut.u_asserts.fail_count);
	endtask

	// run limit
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: tests still running after %0d clock cycles", MAX_CYCLES);
			report_counts();
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = 1'b0;
		wb_dat_w    = 32'd0;
		force_nack  = 1'b0;
		errors      = 0;
		cycles      = 0;
		seed        = 32'h4158_3ffd;
		exp_rdata   = 8'h00;
		rdata_known = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		test_idle_after_reset();
		test_init();
		test_write_read();
		test_backpressure();
		test_nack();
		report_counts();
		if (errors == 0 && i_dut.u_asserts.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/mpr121_pkg.sv
design/mpr121_cmd_fifo.sv
design/mpr121_wb_regs.sv
design/i2c_byte_engine.sv
design/mpr121_sequencer.sv
design/mpr121_top.sv
verification/mpr121_i2c_model.sv
verification/mpr121_asserts.sv
verification/tb_mpr121.sv
